/* rtl/ctrlPkg.sv */
package ctrlPkg;

    // Instruction field widths and codes
    localparam int opcodeWidth = 6;

    localparam logic [opcodeWidth-1:0] opR      = 6'd0;
    localparam logic [opcodeWidth-1:0] opAddiu  = 6'd9;
    localparam logic [opcodeWidth-1:0] functAdd = 6'd32;

    // Step counter width that fits the longest state
    function automatic int unsigned stepBits(int unsigned waitCycles);
        int unsigned maxStep;
        maxStep = (waitCycles > 2) ? waitCycles : 2;
        return $clog2(maxStep + 1);
    endfunction

    typedef enum logic [1:0] {
        clsAdd,
        clsAddiu,
        clsInvalid
    } instrClass_t;

    typedef enum logic [2:0] {
        stReset,
        stFetch,
        stDecode,
        stAdd,
        stAddiu,
        stExcept,
        stHalt
    } state_t;

    typedef enum logic {
        srcAPc,
        srcARegA
    } aluSrcA_t;

    typedef enum logic [1:0] {
        srcBRegB,
        srcBFour,
        srcBSignImm,
        srcBBranchOff
    } aluSrcB_t;

    typedef enum logic {
        aluNone,
        aluAdd
    } aluOp_t;

    typedef enum logic {
        dstRt,
        dstRd
    } regDst_t;

    // Datapath mux still has a select port
    typedef enum logic {
        wbAluOut
    } memToReg_t;

    typedef enum logic {
        pcAluResult,
        pcExceptVector
    } pcSource_t;

    typedef enum logic {
        causeOpcode,
        causeOverflow
    } cause_t;

    typedef struct packed {
        aluSrcA_t   aluSrcA;
        aluSrcB_t   aluSrcB;
        aluOp_t     aluOperation;
        logic       aluOutWrite;
        logic       writeA;
        logic       writeB;
        logic       irWrite;
        pcSource_t  pcSource;
        logic       pcWrite;
        regDst_t    regDst;
        memToReg_t  memToReg;
        logic       regWr;
        logic       epcWrite;
        cause_t     cause;
    } ctrlWord_t;

    localparam ctrlWord_t ctrlIdle = '{
        aluSrcA:      srcAPc,
        aluSrcB:      srcBRegB,
        aluOperation: aluNone,
        aluOutWrite:  1'b0,
        writeA:       1'b0,
        writeB:       1'b0,
        irWrite:      1'b0,
        pcSource:     pcAluResult,
        pcWrite:      1'b0,
        regDst:       dstRt,
        memToReg:     wbAluOut,
        regWr:        1'b0,
        epcWrite:     1'b0,
        cause:        causeOpcode
    };

endpackage

/* rtl/opcodeDecoder.sv */
`timescale 1ns/1ps

module opcodeDecoder
    import ctrlPkg::*;
(
    input  logic [opcodeWidth-1:0] opCode,
    input  logic [opcodeWidth-1:0] funct,
    output instrClass_t            instrClass
);

    // Anything but ADD and ADDIU traps
    always_comb begin
        instrClass = clsInvalid;
        case (opCode)
            opR: begin
                if (funct == functAdd) begin
                    instrClass = clsAdd;
                end
            end
            opAddiu: begin
                instrClass = clsAddiu;
            end
            default: begin
                instrClass = clsInvalid;
            end
        endcase
    end

endmodule

/* rtl/phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer
    import ctrlPkg::*;
#(
    parameter int memWaitCycles = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  instrClass_t                          instrClass,
    input  logic                                 overflow,
    output state_t                               state,
    output logic [stepBits(memWaitCycles)-1:0]   step,
    output logic                                 lastStep,
    output cause_t                               cause,
    output logic                                 resetOut
);

    localparam int stepWidth = stepBits(memWaitCycles);

    // Index of the final step in each state
    localparam logic [stepWidth-1:0] fetchLast  = stepWidth'(memWaitCycles);
    localparam logic [stepWidth-1:0] decodeLast = stepWidth'(1);
    localparam logic [stepWidth-1:0] addLast    = stepWidth'(2);
    localparam logic [stepWidth-1:0] addiuLast  = stepWidth'(1);

    // ADD samples overflow at the end of this step
    localparam logic [stepWidth-1:0] addCheckStep = stepWidth'(1);

    state_t nextState;
    cause_t nextCause;

    always_comb begin
        case (state)
            stFetch:  lastStep = (step == fetchLast);
            stDecode: lastStep = (step == decodeLast);
            stAdd:    lastStep = (step == addLast);
            stAddiu:  lastStep = (step == addiuLast);
            default:  lastStep = 1'b1;
        endcase
    end

    always_comb begin
        nextState = state;
        nextCause = cause;
        case (state)
            stReset: begin
                nextState = stFetch;
            end
            stFetch: begin
                if (lastStep) begin
                    nextState = stDecode;
                end
            end
            stDecode: begin
                if (lastStep) begin
                    case (instrClass)
                        clsAdd:   nextState = stAdd;
                        clsAddiu: nextState = stAddiu;
                        default: begin
                            nextState = stExcept;
                            nextCause = causeOpcode;
                        end
                    endcase
                end
            end
            stAdd: begin
                if (step == addCheckStep && overflow) begin
                    nextState = stExcept;
                    nextCause = causeOverflow;
                end else if (lastStep) begin
                    nextState = stFetch;
                end
            end
            stAddiu: begin
                if (lastStep) begin
                    nextState = stFetch;
                end
            end
            stExcept: begin
                nextState = stHalt;
            end
            default: begin
                // Halted until reset
                nextState = stHalt;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stReset;
            step  <= '0;
            cause <= causeOpcode;
        end else begin
            state <= nextState;
            cause <= nextCause;
            if (nextState != state || lastStep) begin
                step <= '0;
            end else begin
                step <= step + stepWidth'(1);
            end
        end
    end

    assign resetOut = (state == stReset);

endmodule

/* rtl/controlEncoder.sv */
`timescale 1ns/1ps

module controlEncoder
    import ctrlPkg::*;
#(
    parameter int stepWidth = 2
) (
    input  state_t               state,
    input  logic [stepWidth-1:0] step,
    input  logic                 lastStep,
    input  cause_t               cause,
    output ctrlWord_t            ctrl
);

    localparam logic [stepWidth-1:0] computeStep = stepWidth'(0);
    localparam logic [stepWidth-1:0] writeStep   = stepWidth'(2);

    always_comb begin
        ctrl = ctrlIdle;
        case (state)
            stFetch: begin
                // PC + 4 while memory responds
                ctrl.aluSrcA      = srcAPc;
                ctrl.aluSrcB      = srcBFour;
                ctrl.aluOperation = aluAdd;
                ctrl.pcSource     = pcAluResult;
                if (lastStep) begin
                    ctrl.irWrite = 1'b1;
                    ctrl.pcWrite = 1'b1;
                end
            end

            stDecode: begin
                // Branch target computed ahead of dispatch
                ctrl.aluSrcA      = srcAPc;
                ctrl.aluSrcB      = srcBBranchOff;
                ctrl.aluOperation = aluAdd;
                ctrl.aluOutWrite  = 1'b1;
                ctrl.writeA       = 1'b1;
                ctrl.writeB       = 1'b1;
            end

            stAdd: begin
                if (step == computeStep) begin
                    ctrl.aluSrcA      = srcARegA;
                    ctrl.aluSrcB      = srcBRegB;
                    ctrl.aluOperation = aluAdd;
                    ctrl.aluOutWrite  = 1'b1;
                end else if (step == writeStep) begin
                    ctrl.regWr    = 1'b1;
                    ctrl.regDst   = dstRd;
                    ctrl.memToReg = wbAluOut;
                end
                // Step 1 stays idle while overflow is checked
            end

            stAddiu: begin
                if (lastStep) begin
                    ctrl.regWr    = 1'b1;
                    ctrl.regDst   = dstRt;
                    ctrl.memToReg = wbAluOut;
                end else begin
                    ctrl.aluSrcA      = srcARegA;
                    ctrl.aluSrcB      = srcBSignImm;
                    ctrl.aluOperation = aluAdd;
                    ctrl.aluOutWrite  = 1'b1;
                end
            end

            stExcept: begin
                ctrl.epcWrite = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcExceptVector;
                ctrl.cause    = cause;
            end

            default: begin
                // Reset and halt
                ctrl = ctrlIdle;
            end
        endcase
    end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
    import ctrlPkg::*;
#(
    parameter int memWaitCycles = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [opcodeWidth-1:0] opCode,
    input  logic [opcodeWidth-1:0] funct,
    input  logic                   overflow,
    output ctrlWord_t              ctrl,
    output logic                   resetOut
);

    localparam int stepWidth = stepBits(memWaitCycles);

    instrClass_t          instrClass;
    state_t               state;
    logic [stepWidth-1:0] step;
    logic                 lastStep;
    cause_t               cause;

    opcodeDecoder opcodeDecoder_i (
        .opCode     (opCode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    phaseSequencer #(
        .memWaitCycles (memWaitCycles)
    ) phaseSequencer_i (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state),
        .step       (step),
        .lastStep   (lastStep),
        .cause      (cause),
        .resetOut   (resetOut)
    );

    controlEncoder #(
        .stepWidth (stepWidth)
    ) controlEncoder_i (
        .state    (state),
        .step     (step),
        .lastStep (lastStep),
        .cause    (cause),
        .ctrl     (ctrl)
    );

endmodule

/* testbench/controlChecker.sv */
`timescale 1ns/1ps

module controlChecker
    import ctrlPkg::*;
#(
    parameter int memWaitCycles = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [opcodeWidth-1:0] opCode,
    input  logic [opcodeWidth-1:0] funct,
    input  logic                   overflow,
    input  ctrlWord_t              ctrl,
    input  logic                   resetOut,
    output int                     errorCount,
    output int                     instrCount,
    output int                     addCount,
    output int                     addiuCount,
    output int                     invalidCount,
    output int                     overflowCount
);

    // Model of the phase and step that the DUT should be in
    state_t mState = stReset;
    int     mStep = 0;
    cause_t mCause = causeOpcode;
    logic   modelValid = 1'b0;

    int errors = 0;
    int instrs = 0;
    int adds = 0;
    int addius = 0;
    int invalids = 0;
    int overflows = 0;

    assign errorCount    = errors;
    assign instrCount    = instrs;
    assign addCount      = adds;
    assign addiuCount    = addius;
    assign invalidCount  = invalids;
    assign overflowCount = overflows;

    function automatic ctrlWord_t expectedCtrl(state_t st, int stp, cause_t c);
        ctrlWord_t w;
        w = ctrlIdle;
        case (st)
            stFetch: begin
                w.aluSrcB      = srcBFour;
                w.aluOperation = aluAdd;
                if (stp == memWaitCycles) begin
                    w.irWrite = 1'b1;
                    w.pcWrite = 1'b1;
                end
            end
            stDecode: begin
                w.aluSrcB      = srcBBranchOff;
                w.aluOperation = aluAdd;
                w.aluOutWrite  = 1'b1;
                w.writeA       = 1'b1;
                w.writeB       = 1'b1;
            end
            stAdd, stAddiu: begin
                if (stp == 0) begin
                    w.aluSrcA      = srcARegA;
                    w.aluSrcB      = (st == stAdd) ? srcBRegB : srcBSignImm;
                    w.aluOperation = aluAdd;
                    w.aluOutWrite  = 1'b1;
                end else if (st == stAddiu || stp == 2) begin
                    w.regWr  = 1'b1;
                    w.regDst = (st == stAdd) ? dstRd : dstRt;
                end
            end
            stExcept: begin
                w.epcWrite = 1'b1;
                w.pcWrite  = 1'b1;
                w.pcSource = pcExceptVector;
                w.cause    = c;
            end
            default: begin
                w = ctrlIdle;
            end
        endcase
        return w;
    endfunction

    task automatic checkField(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d in %s step %0d",
                     $time, name, got, expected, mState.name(), mStep);
        end
    endtask

    task automatic compareOutputs();
        ctrlWord_t e;
        e = expectedCtrl(mState, mStep, mCause);
        checkField("resetOut", int'(resetOut), int'(mState == stReset));
        checkField("aluSrcA", int'(ctrl.aluSrcA), int'(e.aluSrcA));
        checkField("aluSrcB", int'(ctrl.aluSrcB), int'(e.aluSrcB));
        checkField("aluOperation", int'(ctrl.aluOperation), int'(e.aluOperation));
        checkField("aluOutWrite", int'(ctrl.aluOutWrite), int'(e.aluOutWrite));
        checkField("writeA", int'(ctrl.writeA), int'(e.writeA));
        checkField("writeB", int'(ctrl.writeB), int'(e.writeB));
        checkField("irWrite", int'(ctrl.irWrite), int'(e.irWrite));
        checkField("pcSource", int'(ctrl.pcSource), int'(e.pcSource));
        checkField("pcWrite", int'(ctrl.pcWrite), int'(e.pcWrite));
        checkField("regDst", int'(ctrl.regDst), int'(e.regDst));
        checkField("memToReg", int'(ctrl.memToReg), int'(e.memToReg));
        checkField("regWr", int'(ctrl.regWr), int'(e.regWr));
        checkField("epcWrite", int'(ctrl.epcWrite), int'(e.epcWrite));
        checkField("cause", int'(ctrl.cause), int'(e.cause));
    endtask

    task automatic enter(input state_t st);
        mState = st;
        mStep  = 0;
    endtask

    always @(posedge clk) begin
        if (modelValid) begin
            compareOutputs();
        end
        if (reset) begin
            enter(stReset);
            modelValid = 1'b1;
        end else if (modelValid) begin
            case (mState)
                stReset: enter(stFetch);
                stFetch: begin
                    if (mStep == memWaitCycles) enter(stDecode);
                    else mStep++;
                end
                stDecode: begin
                    if (mStep < 1) begin
                        mStep++;
                    end else if (opCode == opR && funct == functAdd) begin
                        enter(stAdd);
                    end else if (opCode == opAddiu) begin
                        enter(stAddiu);
                    end else begin
                        mCause = causeOpcode;
                        enter(stExcept);
                    end
                end
                stAdd: begin
                    if (mStep == 1 && overflow) begin
                        mCause = causeOverflow;
                        enter(stExcept);
                    end else if (mStep == 2) begin
                        adds++;
                        instrs++;
                        enter(stFetch);
                    end else begin
                        mStep++;
                    end
                end
                stAddiu: begin
                    if (mStep == 1) begin
                        addius++;
                        instrs++;
                        enter(stFetch);
                    end else begin
                        mStep++;
                    end
                end
                stExcept: begin
                    if (mCause == causeOverflow) overflows++;
                    else invalids++;
                    instrs++;
                    enter(stHalt);
                end
                default: mState = stHalt;
            endcase
        end
    end

endmodule

/* testbench/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb
    import ctrlPkg::*;
;

    localparam int memWaitCycles = 3;
    localparam int instrTarget   = 300;
    localparam int timeoutCycles = instrTarget * (memWaitCycles + 20);

    logic                   clk = 1'b0;
    logic                   reset;
    logic [opcodeWidth-1:0] opCode;
    logic [opcodeWidth-1:0] funct;
    logic                   overflow;
    ctrlWord_t              ctrl;
    logic                   resetOut;

    int errorCount;
    int instrCount;
    int addCount;
    int addiuCount;
    int invalidCount;
    int overflowCount;

    logic [31:0] lcgState = 32'hfaf8_852a;
    int          cycleCount = 0;
    int          missingClasses = 0;
    logic        exceptSeen = 1'b0;
    int          idleRun = 0;

    always #2 clk = ~clk;

    controlUnit #(
        .memWaitCycles (memWaitCycles)
    ) controlUnit_i (
        .clk      (clk),
        .reset    (reset),
        .opCode   (opCode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    controlChecker #(
        .memWaitCycles (memWaitCycles)
    ) controlChecker_i (
        .clk           (clk),
        .reset         (reset),
        .opCode        (opCode),
        .funct         (funct),
        .overflow      (overflow),
        .ctrl          (ctrl),
        .resetOut      (resetOut),
        .errorCount    (errorCount),
        .instrCount    (instrCount),
        .addCount      (addCount),
        .addiuCount    (addiuCount),
        .invalidCount  (invalidCount),
        .overflowCount (overflowCount)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // New opcode, funct and overflow on each falling edge
    task automatic driveCycle();
        logic [31:0] r;
        @(negedge clk);
        r = nextRandom();
        funct = opcodeWidth'(nextRandom() >> 26);
        if (r[31:29] < 3'd3) begin
            opCode = opR;
            funct  = functAdd;
        end else if (r[31:29] < 3'd5) begin
            opCode = opAddiu;
        end else if (r[31:29] == 3'd5) begin
            opCode = opR;
        end else begin
            opCode = r[25:20];
        end
        r = nextRandom();
        overflow = (r[31:30] == 2'b00);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (10) driveCycle();
        reset = 1'b0;
        exceptSeen = 1'b0;
        idleRun = 0;
    endtask

    // Halt shows as two idle cycles after the exception cycle
    task automatic trackHalt();
        if (ctrl.epcWrite) begin
            exceptSeen = 1'b1;
            idleRun = 0;
        end else if (exceptSeen && ctrl == ctrlIdle) begin
            idleRun++;
            if (idleRun == 2) begin
                applyReset();
            end
        end
    endtask

    task automatic requireCompleted(input string name, input int count);
        if (count == 0) begin
            $display("No %s instruction was completed during the run", name);
            missingClasses++;
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: %0d instructions did not finish within %0d cycles",
                     instrTarget, timeoutCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        opCode   = '0;
        funct    = '0;
        overflow = 1'b0;
        applyReset();
        while (instrCount < instrTarget) begin
            driveCycle();
            trackHalt();
        end
        requireCompleted("ADD", addCount);
        requireCompleted("ADDIU", addiuCount);
        requireCompleted("invalid-opcode", invalidCount);
        requireCompleted("overflowing ADD", overflowCount);
        $display("Errors: %0d, ADD: %0d, ADDIU: %0d, invalid: %0d, overflow: %0d",
                 errorCount, addCount, addiuCount, invalidCount, overflowCount);
        if (errorCount == 0 && missingClasses == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/ctrlPkg.sv
rtl/opcodeDecoder.sv
rtl/phaseSequencer.sv
rtl/controlEncoder.sv
rtl/controlUnit.sv
testbench/controlChecker.sv
testbench/controlUnitTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = controlUnitTb
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
